/* sim/cjtag_bridge_trace.txt */
# Columns: command, then its arguments
# ESC toggles | ACT bit_count packet_hex_lsb_first | SCAN ntdi tms tdo | CHK online
# Reset state
CHK 0
# Selection with 6 toggles, then the good packet
ESC 6
ACT 12 48c
CHK 1
# OScan1 traffic
SCAN 0 1 1
SCAN 1 0 0
SCAN 0 0 1
SCAN 1 1 0
# Short escape keeps the link, deselection drops it
ESC 3
CHK 1
ESC 4
CHK 0
# Selection with 7 toggles, wrong CP
ESC 7
ACT 12 58c
CHK 0
# Wrong OAC with a consistent CP
ESC 6
ACT 12 58d
CHK 0
# Reset escape in the middle of activation
ESC 6
ACT 5 48c
ESC 8
CHK 0
# Fresh activation
ESC 6
ACT 12 48c
CHK 1
SCAN 1 1 1
SCAN 0 0 0
ESC 0
CHK 1
ESC 5
CHK 0
# Reset escape out of OScan1
ESC 7
ACT 12 48c
CHK 1
SCAN 0 1 0
ESC 10
CHK 0

/* cjtag_bridge.f */
hdl/cjtag_pkg.sv
hdl/cjtag_input_sync.sv
hdl/cjtag_escape_detect.sv
hdl/cjtag_control_fsm.sv
hdl/oscan1_jtag_driver.sv
hdl/cjtag_bridge.sv
sim/cjtag_bridge_assertions.sv
sim/cjtag_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cJTAG bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim_run.log
BIN=cjtag_bridge_sim

# Compile the testbench and the RTL
verilator --binary --timing --assert --top-module cjtag_bridge_tb \
    -f cjtag_bridge.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Run and keep the log for the verdict
./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Verdict from the log
if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
    echo "No verdict found in $LOG"
    exit 1
fi
exit 0

/* sim/cjtag_bridge_tb.sv */
`timescale 1ns/1ps

module cjtag_bridge_tb;

    import cjtag_pkg::*;

    // DUT pins
    logic clk_i;
    logic ntrst_i;
    logic tckc_i;
    logic tmsc_i;
    logic tdo_i;
    logic tmsc_o;
    logic tmsc_oen;
    logic tck_o;
    logic tms_o;
    logic tdi_o;
    logic online_o;
    logic nsp_o;

    // Error counters, one per kind of result
    int online_errors;
    int idle_errors;
    int jtag_errors;
    int tdo_errors;
    int pulse_errors;
    // Set on a timeout or a bad trace, stops the trace loop
    logic run_aborted;
    // TCK pulses seen by the TAP model
    int tck_pulses = 0;

    cjtag_bridge cjtag_bridge_inst (
        .clk_i    (clk_i),
        .ntrst_i  (ntrst_i),
        .tckc_i   (tckc_i),
        .tmsc_i   (tmsc_i),
        .tdo_i    (tdo_i),
        .tmsc_o   (tmsc_o),
        .tmsc_oen (tmsc_oen),
        .tck_o    (tck_o),
        .tms_o    (tms_o),
        .tdi_o    (tdi_o),
        .online_o (online_o),
        .nsp_o    (nsp_o)
    );

    // Protocol rules on the bridge pins
    bind cjtag_bridge cjtag_bridge_assertions assertions_inst (
        .clk_i    (clk_i),
        .ntrst_i  (ntrst_i),
        .tmsc_oen (tmsc_oen),
        .tck_o    (tck_o),
        .tms_o    (tms_o),
        .online_o (online_o),
        .nsp_o    (nsp_o)
    );

    // 10 ns system clock
    always #5 clk_i = ~clk_i;

    // TAP model, counts TCK pulses
    always @(posedge tck_o) begin
        tck_pulses = tck_pulses + 1;
    end

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_online(input logic got_online, input logic got_nsp,
                                input logic exp_online);
        if (got_online !== exp_online || got_nsp !== ~exp_online) begin
            online_errors++;
            $display("Error at %0t: online_o %b nsp_o %b, expected %b and %b",
                     $time, got_online, got_nsp, exp_online, ~exp_online);
        end
    endtask

    // Offline pins: TCK low, TMS high, TDI low, TMSC released
    task automatic check_idle(input logic got_tck, input logic got_tms,
                              input logic got_tdi, input logic got_oen);
        if (got_tck !== 1'b0 || got_tms !== 1'b1 || got_tdi !== 1'b0 || got_oen !== 1'b1) begin
            idle_errors++;
            $display("Error at %0t: idle pins tck %b tms %b tdi %b oen %b, expected 0 1 0 1",
                     $time, got_tck, got_tms, got_tdi, got_oen);
        end
    endtask

    task automatic check_jtag(input logic got_tdi, input logic got_tms,
                              input logic exp_tdi, input logic exp_tms);
        if (got_tdi !== exp_tdi || got_tms !== exp_tms) begin
            jtag_errors++;
            $display("Error at %0t: at TCK rise tdi_o %b tms_o %b, expected %b and %b",
                     $time, got_tdi, got_tms, exp_tdi, exp_tms);
        end
    endtask

    task automatic check_tdo(input logic got_tmsc, input logic got_oen, input logic exp_tdo);
        if (got_tmsc !== exp_tdo || got_oen !== 1'b0) begin
            tdo_errors++;
            $display("Error at %0t: return bit tmsc_o %b oen %b, expected %b with oen 0",
                     $time, got_tmsc, got_oen, exp_tdo);
        end
    endtask

    task automatic check_pulses(input int got, input int exp);
        if (got != exp) begin
            pulse_errors++;
            $display("Error at %0t: %0d TCK pulses in the packet, expected %0d",
                     $time, got, exp);
        end
    endtask

    // ========================================
    // Probe model
    // ========================================
    // Inputs change 1 ns after the rising edge
    task automatic next_drive();
        @(posedge clk_i);
        #1;
    endtask

    // One TCKC cycle, TMSC moves mid way through the low phase
    task automatic send_bit(input logic tmsc_val);
        repeat (3) next_drive();
        tmsc_i = tmsc_val;
        repeat (3) next_drive();
        tckc_i = 1'b1;
        repeat (6) next_drive();
        tckc_i = 1'b0;
    endtask

    // TMSC toggles every 2 clocks while TCKC is high
    task automatic send_escape(input toggle_count_t toggles);
        int high_clocks;
        high_clocks = 2 * int'(toggles) + 2;
        if (high_clocks < 6) begin
            high_clocks = 6;
        end
        repeat (6) next_drive();
        tckc_i = 1'b1;
        repeat (2) next_drive();
        for (int i = 0; i < int'(toggles); i++) begin
            tmsc_i = ~tmsc_i;
            repeat (2) next_drive();
        end
        // Last toggle must land before the fall
        repeat (high_clocks - 2 - 2 * int'(toggles)) next_drive();
        tckc_i = 1'b0;
    endtask

    // Activation bits go out LSB first
    task automatic send_activation(input int nbits, input act_packet_t packet);
        act_packet_t shift_q;
        shift_q = packet;
        for (int i = 0; i < nbits; i++) begin
            send_bit(shift_q[0]);
            shift_q = shift_q >> 1;
        end
    endtask

    task automatic wait_tck_high();
        int clocks;
        clocks = 0;
        @(negedge clk_i);
        while (tck_o !== 1'b1 && clocks < 200) begin
            @(negedge clk_i);
            clocks++;
        end
        if (tck_o !== 1'b1) begin
            $display("Timeout: tck_o did not rise within 200 clocks of the TCKC rise");
            run_aborted = 1'b1;
        end
    endtask

    task automatic wait_oen_low();
        int clocks;
        clocks = 0;
        while (tmsc_oen !== 1'b0 && clocks < 200) begin
            @(negedge clk_i);
            clocks++;
        end
        if (tmsc_oen !== 1'b0) begin
            $display("Timeout: tmsc_oen did not go low within 200 clocks in the third bit");
            run_aborted = 1'b1;
        end
    endtask

    // OScan1 packet: nTDI, TMS, then the TDO return bit
    task automatic send_scan(input logic ntdi, input logic tms, input logic tdo);
        int pulses_before;
        pulses_before = tck_pulses;
        send_bit(ntdi);
        send_bit(tms);
        // TAP model presents TDO before TCK rises
        repeat (3) next_drive();
        tdo_i = tdo;
        repeat (3) next_drive();
        tckc_i = 1'b1;
        wait_tck_high();
        if (!run_aborted) begin
            // TDI carries the inverse of nTDI
            check_jtag(tdi_o, tms_o, ~ntdi, tms);
            // One clock for the TDO capture
            @(negedge clk_i);
            wait_oen_low();
        end
        if (!run_aborted) begin
            check_tdo(tmsc_o, tmsc_oen, tdo);
            next_drive();
            tckc_i = 1'b0;
            check_pulses(tck_pulses - pulses_before, 1);
        end
    endtask

    // Pin change shows 4 clocks later, one low phase is enough
    task automatic settle_and_check(input logic exp_online);
        repeat (6) next_drive();
        @(negedge clk_i);
        check_online(online_o, nsp_o, exp_online);
        if (!exp_online) begin
            check_idle(tck_o, tms_o, tdi_o, tmsc_oen);
        end
    endtask

    // ========================================
    // Trace interpreter
    // ========================================
    task automatic run_command(input string line);
        string         cmd;
        int            fields;
        logic          bad;
        toggle_count_t toggles;
        int            nbits;
        act_packet_t   packet;
        logic          arg_a;
        logic          arg_b;
        logic          arg_c;
        bad = 1'b0;
        fields = $sscanf(line, "%s", cmd);
        if (cmd == "ESC") begin
            fields = $sscanf(line, "%s %d", cmd, toggles);
            if (fields == 2) send_escape(toggles);
            else bad = 1'b1;
        end else if (cmd == "ACT") begin
            fields = $sscanf(line, "%s %d %h", cmd, nbits, packet);
            if (fields == 3) send_activation(nbits, packet);
            else bad = 1'b1;
        end else if (cmd == "SCAN") begin
            fields = $sscanf(line, "%s %b %b %b", cmd, arg_a, arg_b, arg_c);
            if (fields == 4) send_scan(arg_a, arg_b, arg_c);
            else bad = 1'b1;
        end else if (cmd == "CHK") begin
            fields = $sscanf(line, "%s %b", cmd, arg_a);
            if (fields == 2) settle_and_check(arg_a);
            else bad = 1'b1;
        end else begin
            bad = 1'b1;
        end
        if (bad) begin
            $display("The trace holds a line that cannot be read: %s", line);
            run_aborted = 1'b1;
        end
    endtask

    initial begin
        int    fd;
        int    got;
        string line;
        clk_i         = 1'b0;
        ntrst_i       = 1'b0;
        tckc_i        = 1'b0;
        tmsc_i        = 1'b0;
        tdo_i         = 1'b0;
        online_errors = 0;
        idle_errors   = 0;
        jtag_errors   = 0;
        tdo_errors    = 0;
        pulse_errors  = 0;
        run_aborted   = 1'b0;
        // Reset for two clocks
        repeat (2) @(posedge clk_i);
        #1;
        ntrst_i = 1'b1;
        fd = $fopen("sim/cjtag_bridge_trace.txt", "r");
        if (fd == 0) begin
            $display("The trace file sim/cjtag_bridge_trace.txt could not be opened");
            run_aborted = 1'b1;
        end else begin
            while (!run_aborted && !$feof(fd)) begin
                got = $fgets(line, fd);
                // Skip comments and blank lines
                if (got > 1 && line.getc(0) != "#") begin
                    run_command(line);
                end
            end
            $fclose(fd);
        end
        $display("Errors: online %0d, idle %0d, jtag %0d, tdo %0d, pulses %0d",
                 online_errors, idle_errors, jtag_errors, tdo_errors, pulse_errors);
        if (run_aborted ||
            (online_errors + idle_errors + jtag_errors + tdo_errors + pulse_errors) != 0) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

/* sim/cjtag_bridge_assertions.sv */
`timescale 1ns/1ps

module cjtag_bridge_assertions (
    input logic clk_i,
    input logic ntrst_i,
    input logic tmsc_oen,
    input logic tck_o,
    input logic tms_o,
    input logic online_o,
    input logic nsp_o
);

    // ========================================
    // Pin rules at the bridge boundary
    // ========================================

    // Bridge drives TMSC only in OScan1
    oen_online_a: assert property (@(posedge clk_i) disable iff (!ntrst_i)
        !tmsc_oen |-> online_o)
        else $error("tmsc_oen low while the bridge is offline");

    // No TCK pulse outside OScan1
    tck_online_a: assert property (@(posedge clk_i) disable iff (!ntrst_i)
        tck_o |-> online_o)
        else $error("tck_o high while the bridge is offline");

    nsp_inverse_a: assert property (@(posedge clk_i) disable iff (!ntrst_i)
        nsp_o == !online_o)
        else $error("nsp_o is not the inverse of online_o");

    // TMS idles high, one clock after leaving OScan1
    tms_idle_a: assert property (@(posedge clk_i) disable iff (!ntrst_i)
        (!online_o && !$past(online_o)) |-> tms_o)
        else $error("tms_o low while the bridge is offline");

endmodule

/* hdl/cjtag_bridge.sv */
`timescale 1ns/1ps

module cjtag_bridge (
    input  logic clk_i,
    input  logic ntrst_i,
    input  logic tckc_i,
    input  logic tmsc_i,
    input  logic tdo_i,
    output logic tmsc_o,
    output logic tmsc_oen,
    output logic tck_o,
    output logic tms_o,
    output logic tdi_o,
    output logic online_o,
    output logic nsp_o
);

    import cjtag_pkg::*;

    // Synchronized pins and edge pulses
    logic tckc_s;
    logic tmsc_s;
    logic tckc_posedge;
    logic tckc_negedge;
    logic tmsc_edge;

    escape_kind_t  esc_kind;
    bridge_state_t state;
    oscan_phase_t  phase;
    // Last non-escape TMSC bit in OScan1
    logic          tmsc_bit;

    // ========================================
    // Input side
    // ========================================
    cjtag_input_sync input_sync_inst (
        .clk_i          (clk_i),
        .ntrst_i        (ntrst_i),
        .tckc_i         (tckc_i),
        .tmsc_i         (tmsc_i),
        .tckc_s_o       (tckc_s),
        .tmsc_s_o       (tmsc_s),
        .tckc_posedge_o (tckc_posedge),
        .tckc_negedge_o (tckc_negedge),
        .tmsc_edge_o    (tmsc_edge)
    );

    cjtag_escape_detect escape_detect_inst (
        .clk_i          (clk_i),
        .ntrst_i        (ntrst_i),
        .tckc_s_i       (tckc_s),
        .tckc_posedge_i (tckc_posedge),
        .tckc_negedge_i (tckc_negedge),
        .tmsc_edge_i    (tmsc_edge),
        .esc_kind_o     (esc_kind)
    );

    // ========================================
    // Control and JTAG side
    // ========================================
    cjtag_control_fsm control_fsm_inst (
        .clk_i          (clk_i),
        .ntrst_i        (ntrst_i),
        .tckc_negedge_i (tckc_negedge),
        .tmsc_s_i       (tmsc_s),
        .esc_kind_i     (esc_kind),
        .state_o        (state),
        .phase_o        (phase),
        .tmsc_bit_o     (tmsc_bit)
    );

    oscan1_jtag_driver jtag_driver_inst (
        .clk_i          (clk_i),
        .ntrst_i        (ntrst_i),
        .tckc_posedge_i (tckc_posedge),
        .tckc_negedge_i (tckc_negedge),
        .state_i        (state),
        .phase_i        (phase),
        .tmsc_bit_i     (tmsc_bit),
        .tdo_i          (tdo_i),
        .tck_o          (tck_o),
        .tms_o          (tms_o),
        .tdi_o          (tdi_o),
        .tmsc_o         (tmsc_o),
        .tmsc_oen       (tmsc_oen)
    );

    // Status, nsp_o marks the standard protocol when not in OScan1
    assign online_o = (state == OSCAN1);
    assign nsp_o    = ~online_o;

endmodule

/* hdl/oscan1_jtag_driver.sv */
`timescale 1ns/1ps

module oscan1_jtag_driver (
    input  logic                     clk_i,
    input  logic                     ntrst_i,
    input  logic                     tckc_posedge_i,
    input  logic                     tckc_negedge_i,
    input  cjtag_pkg::bridge_state_t state_i,
    input  cjtag_pkg::oscan_phase_t  phase_i,
    input  logic                     tmsc_bit_i,
    input  logic                     tdo_i,
    output logic                     tck_o,
    output logic                     tms_o,
    output logic                     tdi_o,
    output logic                     tmsc_o,
    output logic                     tmsc_oen
);

    import cjtag_pkg::*;

    logic tck_q;
    logic tms_q;
    logic tdi_q;
    // Low while the bridge owns TMSC
    logic oen_q;
    // TDO from the TAP sampled during the TCK pulse
    logic tdo_q;

    logic in_tdo;

    assign in_tdo = (state_i == OSCAN1) && (phase_i == PH_TDO);

    // ========================================
    // JTAG pin generation
    // ========================================
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            tck_q <= 1'b0;
            tms_q <= 1'b1;
            tdi_q <= 1'b0;
            oen_q <= 1'b1;
        end else if (state_i != OSCAN1) begin
            // Idle pins with TMSC left to the probe
            tck_q <= 1'b0;
            tms_q <= 1'b1;
            tdi_q <= 1'b0;
            oen_q <= 1'b1;
        end else if (tckc_posedge_i) begin
            case (phase_i)
                PH_NTDI: begin
                    tck_q <= 1'b0;
                    oen_q <= 1'b1;
                end
                PH_TMS: begin
                    // nTDI was latched on the previous fall
                    tdi_q <= ~tmsc_bit_i;
                    oen_q <= 1'b1;
                end
                PH_TDO: begin
                    // TMS is known now so the TAP gets its clock
                    tms_q <= tmsc_bit_i;
                    tck_q <= 1'b1;
                    oen_q <= 1'b0;
                end
                default: oen_q <= 1'b1;
            endcase
        end else if (tckc_negedge_i && phase_i == PH_TDO) begin
            // TCK falls at the end of the packet and TMSC goes back to the probe
            tck_q <= 1'b0;
            oen_q <= 1'b1;
        end
    end

    // TDO capture while TCK is high
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            tdo_q <= 1'b0;
        end else if (tck_q && in_tdo) begin
            tdo_q <= tdo_i;
        end
    end

    assign tck_o    = tck_q;
    assign tms_o    = tms_q;
    assign tdi_o    = tdi_q;
    // Return path only in the third bit
    assign tmsc_o   = in_tdo ? tdo_q : 1'b0;
    assign tmsc_oen = oen_q;

endmodule

/* hdl/cjtag_control_fsm.sv */
`timescale 1ns/1ps

module cjtag_control_fsm (
    input  logic                     clk_i,
    input  logic                     ntrst_i,
    input  logic                     tckc_negedge_i,
    input  logic                     tmsc_s_i,
    input  cjtag_pkg::escape_kind_t  esc_kind_i,
    output cjtag_pkg::bridge_state_t state_o,
    output cjtag_pkg::oscan_phase_t  phase_o,
    output logic                     tmsc_bit_o
);

    import cjtag_pkg::*;

    bridge_state_t state_q;
    oscan_phase_t  phase_q;
    logic          tmsc_bit_q;

    // First 11 activation bits, the 12th comes straight from TMSC
    logic [$bits(act_packet_t)-2:0] act_shift_q;
    act_count_t                     act_cnt_q;

    // Decoded activation packet
    act_packet_t rx_packet;
    act_field_t  rx_oac;
    act_field_t  rx_ec;
    act_field_t  rx_cp;
    logic        act_ok;

    // ========================================
    // Activation packet check
    // ========================================
    // LSB first, so the oldest bit sits at index 0
    assign rx_packet = {tmsc_s_i, act_shift_q};
    assign rx_oac    = rx_packet[3:0];
    assign rx_ec     = rx_packet[7:4];
    assign rx_cp     = rx_packet[11:8];
    // Fixed OAC and EC, CP is their bitwise parity
    assign act_ok    = (rx_oac == ACT_OAC) && (rx_ec == ACT_EC) && (rx_cp == (rx_oac ^ rx_ec));

    // ========================================
    // Bridge state machine
    // ========================================
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            state_q     <= OFFLINE;
            phase_q     <= PH_NTDI;
            tmsc_bit_q  <= 1'b0;
            act_shift_q <= '0;
            act_cnt_q   <= '0;
        end else if (tckc_negedge_i) begin
            // Everything happens on a TCKC fall
            case (state_q)
                OFFLINE: begin
                    // Only selection wakes the bridge
                    if (esc_kind_i == ESC_SELECT) begin
                        state_q     <= ONLINE_ACT;
                        act_shift_q <= '0;
                        act_cnt_q   <= '0;
                    end
                end

                ONLINE_ACT: begin
                    if (esc_kind_i == ESC_RESET) begin
                        // Abort activation
                        state_q   <= OFFLINE;
                        act_cnt_q <= '0;
                    end else if (act_cnt_q == ACT_LAST_BIT) begin
                        // Whole packet in, accept or drop
                        state_q   <= act_ok ? OSCAN1 : OFFLINE;
                        phase_q   <= PH_NTDI;
                        act_cnt_q <= '0;
                    end else begin
                        act_shift_q <= {tmsc_s_i, act_shift_q[$bits(act_shift_q)-1:1]};
                        act_cnt_q   <= act_cnt_q + 4'd1;
                    end
                end

                OSCAN1: begin
                    if (esc_kind_i == ESC_DESELECT || esc_kind_i == ESC_RESET) begin
                        state_q <= OFFLINE;
                        phase_q <= PH_NTDI;
                    end else begin
                        // Normal packet bit
                        tmsc_bit_q <= tmsc_s_i;
                        case (phase_q)
                            PH_NTDI: phase_q <= PH_TMS;
                            PH_TMS:  phase_q <= PH_TDO;
                            default: phase_q <= PH_NTDI;
                        endcase
                    end
                end

                default: begin
                    state_q <= OFFLINE;
                    phase_q <= PH_NTDI;
                end
            endcase
        end
    end

    assign state_o    = state_q;
    assign phase_o    = phase_q;
    assign tmsc_bit_o = tmsc_bit_q;

endmodule

/* hdl/cjtag_escape_detect.sv */
`timescale 1ns/1ps

module cjtag_escape_detect (
    input  logic                    clk_i,
    input  logic                    ntrst_i,
    input  logic                    tckc_s_i,
    input  logic                    tckc_posedge_i,
    input  logic                    tckc_negedge_i,
    input  logic                    tmsc_edge_i,
    output cjtag_pkg::escape_kind_t esc_kind_o
);

    import cjtag_pkg::*;

    // TMSC toggles since the last TCKC rise
    toggle_count_t toggle_cnt_q;
    // Set between TCKC rise and fall
    logic          tckc_high_q;

    // ========================================
    // Toggle counter
    // ========================================
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            toggle_cnt_q <= '0;
            tckc_high_q  <= 1'b0;
        end else if (tckc_posedge_i) begin
            // Fresh count for every TCKC high phase
            toggle_cnt_q <= '0;
            tckc_high_q  <= 1'b1;
        end else if (tckc_negedge_i) begin
            // Count stays put so the FSM sees it with the fall pulse
            tckc_high_q  <= 1'b0;
        end else if (tckc_high_q && tckc_s_i && tmsc_edge_i) begin
            // Saturate, no wrap back into a lower class
            if (toggle_cnt_q != '1) begin
                toggle_cnt_q <= toggle_cnt_q + 5'd1;
            end
        end
    end

    // ========================================
    // Classification
    // ========================================
    always_comb begin
        if (toggle_cnt_q >= ESC_RESET_MIN) begin
            esc_kind_o = ESC_RESET;
        end else if (toggle_cnt_q >= ESC_SELECT_MIN) begin
            esc_kind_o = ESC_SELECT;
        end else if (toggle_cnt_q >= ESC_DESELECT_MIN) begin
            esc_kind_o = ESC_DESELECT;
        end else begin
            // 0 to 3 toggles, an ordinary TCKC cycle
            esc_kind_o = ESC_NONE;
        end
    end

endmodule

/* hdl/cjtag_input_sync.sv */
`timescale 1ns/1ps

module cjtag_input_sync (
    input  logic clk_i,
    input  logic ntrst_i,
    input  logic tckc_i,
    input  logic tmsc_i,
    output logic tckc_s_o,
    output logic tmsc_s_o,
    output logic tckc_posedge_o,
    output logic tckc_negedge_o,
    output logic tmsc_edge_o
);

    // Two flops per probe pin against metastability
    logic [1:0] tckc_sync_q;
    logic [1:0] tmsc_sync_q;

    // Last synchronized values, for edge compare
    logic tckc_prev_q;
    logic tmsc_prev_q;

    // Registered edge pulses, one clock wide
    logic tckc_rise_q;
    logic tckc_fall_q;
    logic tmsc_chg_q;

    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            tckc_sync_q <= 2'b00;
            tmsc_sync_q <= 2'b00;
            tckc_prev_q <= 1'b0;
            tmsc_prev_q <= 1'b0;
            tckc_rise_q <= 1'b0;
            tckc_fall_q <= 1'b0;
            tmsc_chg_q  <= 1'b0;
        end else begin
            tckc_sync_q <= {tckc_sync_q[0], tckc_i};
            tmsc_sync_q <= {tmsc_sync_q[0], tmsc_i};
            tckc_prev_q <= tckc_sync_q[1];
            tmsc_prev_q <= tmsc_sync_q[1];
            // Compare stage 2 against its delayed copy
            tckc_rise_q <= !tckc_prev_q && tckc_sync_q[1];
            tckc_fall_q <= tckc_prev_q && !tckc_sync_q[1];
            // Any TMSC change counts
            tmsc_chg_q  <= tmsc_prev_q != tmsc_sync_q[1];
        end
    end

    assign tckc_s_o       = tckc_sync_q[1];
    assign tmsc_s_o       = tmsc_sync_q[1];
    assign tckc_posedge_o = tckc_rise_q;
    assign tckc_negedge_o = tckc_fall_q;
    assign tmsc_edge_o    = tmsc_chg_q;

endmodule

/* hdl/cjtag_pkg.sv */
package cjtag_pkg;

    // ========================================
    // Bridge states and escape classes
    // ========================================

    // Top-level bridge mode
    typedef enum logic [2:0] {
        OFFLINE    = 3'b000,
        ONLINE_ACT = 3'b010,
        OSCAN1     = 3'b011
    } bridge_state_t;

    // Escape class, decoded from the TMSC toggles seen while TCKC was high
    typedef enum logic [1:0] {
        ESC_NONE     = 2'b00,
        ESC_DESELECT = 2'b01,
        ESC_SELECT   = 2'b10,
        ESC_RESET    = 2'b11
    } escape_kind_t;

    // Bit position inside a 3-bit OScan1 packet
    typedef enum logic [1:0] {
        PH_NTDI = 2'b00,
        PH_TMS  = 2'b01,
        PH_TDO  = 2'b10
    } oscan_phase_t;

    // ========================================
    // Widths and constants
    // ========================================
    typedef logic [4:0]  toggle_count_t;
    typedef logic [11:0] act_packet_t;
    typedef logic [3:0]  act_field_t;
    typedef logic [3:0]  act_count_t;

    // Lowest toggle count of each escape class
    localparam toggle_count_t ESC_DESELECT_MIN = 5'd4;
    localparam toggle_count_t ESC_SELECT_MIN   = 5'd6;
    localparam toggle_count_t ESC_RESET_MIN    = 5'd8;

    // Expected activation fields, CP is their XOR
    localparam act_field_t ACT_OAC = 4'b1100;
    localparam act_field_t ACT_EC  = 4'b1000;

    // Index of the final activation bit
    localparam act_count_t ACT_LAST_BIT = 4'd11;

endpackage
